//--- design/conv_ctrl_pkg.sv
package conv_ctrl_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////

  // mac steps per tile
  localparam int MAC_COUNT_W = 16;

  // output row index, must hold the array row count
  localparam int ROW_IDX_W = 6;

  // layer mode code
  localparam int MODE_W = 4;

  // mode that sends sums through the multiplier array
  localparam logic [MODE_W-1:0] MODE_MULT_ARRAY = 4'd1;

  ////////////////////////////////////////////////////////////
  // bundles
  ////////////////////////////////////////////////////////////

  // per-tile config, latched on an accepted start
  // mac_count is N, at least 2
  typedef struct packed {
    logic [MODE_W-1:0]      mode;
    logic [MAC_COUNT_W-1:0] mac_count;
  } tile_cfg_t;

  // systolic array controls
  typedef struct packed {
    logic sa_en;
    logic sa_clear;
    logic cell_en;
    logic cell_clear;
    logic cell_output_en;
  } array_ctrl_t;

  // output path controls
  typedef struct packed {
    logic [ROW_IDX_W-1:0] row_idx;
    logic                 sum_receive_en;
  } drain_ctrl_t;

  // scale, bias, relu, fifo controls
  typedef struct packed {
    logic scale_en;
    logic mult_mode;
    logic bias_en;
    logic relu_en;
    logic fifo_en;
    logic tile_done;
  } post_ctrl_t;

endpackage

//--- design/pixel_phase.sv
`timescale 1ns/1ps

module pixel_phase (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             start,
  input  conv_ctrl_pkg::tile_cfg_t         cfg,
  input  logic                             drain_busy,
  output logic                             accepted,
  output logic [conv_ctrl_pkg::MODE_W-1:0] mode,
  output logic                             pixel_last,
  output logic                             pixel_end,
  output logic                             cell_en,
  output logic                             cell_clear
);

  // one spare bit, count goes up to mac_count + 1
  localparam int CNT_W = conv_ctrl_pkg::MAC_COUNT_W + 1;

  conv_ctrl_pkg::tile_cfg_t cfg_q;

  logic             pix_run;
  logic [CNT_W-1:0] pix_cnt;
  logic [CNT_W-1:0] last_cnt;
  logic [CNT_W-1:0] end_cnt;

  ////////////////////////////////////////////////////////////
  // start acceptance
  ////////////////////////////////////////////////////////////

  // both phases must be idle
  // starts during a tile are dropped
  assign accepted = start && !pix_run && !drain_busy;

  // tile config, sampled only on an accepted start
  always_ff @(posedge clk) begin
    if (accepted) begin
      cfg_q <= cfg;
    end
  end

  assign mode = cfg_q.mode;

  ////////////////////////////////////////////////////////////
  // pixel counter
  ////////////////////////////////////////////////////////////

  // N in cycle E-1, N+1 in cycle E
  assign last_cnt   = CNT_W'(cfg_q.mac_count);
  assign end_cnt    = last_cnt + CNT_W'(1);
  assign pixel_last = pix_run && (pix_cnt == last_cnt);
  assign pixel_end  = pix_run && (pix_cnt == end_cnt);

  always_ff @(posedge clk) begin
    if (reset) begin
      pix_run <= 1'b0;
    end else if (accepted) begin
      pix_run <= 1'b1;
    end else if (pixel_end) begin
      pix_run <= 1'b0;
    end
  end

  // idle value is 0, so the count reads 0 in cycle S
  always_ff @(posedge clk) begin
    if (reset) begin
      pix_cnt <= '0;
    end else if (accepted) begin
      pix_cnt <= CNT_W'(1);
    end else if (pixel_end) begin
      pix_cnt <= '0;
    end else if (pix_run) begin
      pix_cnt <= pix_cnt + CNT_W'(1);
    end
  end

  ////////////////////////////////////////////////////////////
  // cell controls
  ////////////////////////////////////////////////////////////

  // window S+2 .. S+N
  // one cycle of slack between the delay regs and the array input
  always_ff @(posedge clk) begin
    if (reset) begin
      cell_en <= 1'b0;
    end else if (pix_run && (pix_cnt == CNT_W'(1))) begin
      cell_en <= 1'b1;
    end else if (pixel_last) begin
      cell_en <= 1'b0;
    end
  end

  // cell (1,1) done, one-shot clear at S+N+1
  always_ff @(posedge clk) begin
    if (reset) begin
      cell_clear <= 1'b0;
    end else begin
      cell_clear <= pixel_last;
    end
  end

endmodule

//--- design/drain_phase.sv
`timescale 1ns/1ps

module drain_phase #(
  parameter int sa_rows = 16
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       accepted,
  input  logic                       pixel_last,
  input  logic                       pixel_end,
  output logic                       sa_en,
  output logic                       sa_clear,
  output logic                       cell_output_en,
  output conv_ctrl_pkg::drain_ctrl_t drain,
  output logic                       drain_busy,
  output logic                       drain_end
);

  // counter spans 0 .. 2R+1
  localparam int CNT_W = $clog2(2 * sa_rows + 2);
  localparam int IDX_W = conv_ctrl_pkg::ROW_IDX_W;

  // decode points, counter value c is j in cycle E+j
  localparam logic [CNT_W-1:0] C_HOLD_END = CNT_W'(2 * sa_rows - 2);
  localparam logic [CNT_W-1:0] C_END_PRE  = CNT_W'(2 * sa_rows - 1);
  localparam logic [CNT_W-1:0] C_WIN_END  = CNT_W'(2 * sa_rows);
  localparam logic [CNT_W-1:0] C_LAST     = CNT_W'(2 * sa_rows + 1);
  localparam logic [CNT_W-1:0] C_RX_ON    = CNT_W'(sa_rows + 1);
  localparam logic [CNT_W-1:0] C_IDX_LO   = CNT_W'(sa_rows);
  localparam logic [CNT_W-1:0] C_IDX_OFS  = CNT_W'(sa_rows - 1);

  logic             drain_run;
  logic             drain_act;
  logic             drain_last;
  logic [CNT_W-1:0] row_cnt;
  logic [CNT_W-1:0] idx_full;
  logic             sa_hold;

  ////////////////////////////////////////////////////////////
  // row counter
  ////////////////////////////////////////////////////////////

  // live from pixel_end (cycle E) through E+2R+1
  assign drain_act  = pixel_end || drain_run;
  assign drain_last = drain_act && (row_cnt == C_LAST);

  always_ff @(posedge clk) begin
    if (reset) begin
      drain_run <= 1'b0;
    end else if (pixel_end) begin
      drain_run <= 1'b1;
    end else if (drain_last) begin
      drain_run <= 1'b0;
    end
  end

  // rests at 0, so it reads 0 in cycle E
  always_ff @(posedge clk) begin
    if (reset) begin
      row_cnt <= '0;
    end else if (drain_act) begin
      if (drain_last) begin
        row_cnt <= '0;
      end else begin
        row_cnt <= row_cnt + CNT_W'(1);
      end
    end
  end

  // pixel side holds off new starts until E+2R+2
  assign drain_busy = drain_run;

  ////////////////////////////////////////////////////////////
  // array enable and clear
  ////////////////////////////////////////////////////////////

  // held S+1 .. E+2R-2
  always_ff @(posedge clk) begin
    if (reset) begin
      sa_hold <= 1'b0;
    end else if (accepted) begin
      sa_hold <= 1'b1;
    end else if (drain_act && (row_cnt == C_HOLD_END)) begin
      sa_hold <= 1'b0;
    end
  end

  // array delay regs want the enable already in cycle S
  assign sa_en = sa_hold || accepted;

  // one pulse at E+2R-1, right after the enable drops
  always_ff @(posedge clk) begin
    if (reset) begin
      sa_clear <= 1'b0;
    end else begin
      sa_clear <= drain_act && (row_cnt == C_HOLD_END);
    end
  end

  // cell outputs shift out E .. E+2R
  always_ff @(posedge clk) begin
    if (reset) begin
      cell_output_en <= 1'b0;
    end else if (pixel_last) begin
      cell_output_en <= 1'b1;
    end else if (drain_act && (row_cnt == C_WIN_END)) begin
      cell_output_en <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // output window
  ////////////////////////////////////////////////////////////

  // row k shows at E+R+k, k = 1 .. R
  assign idx_full = row_cnt - C_IDX_OFS;

  always_ff @(posedge clk) begin
    if (reset) begin
      drain.row_idx <= '0;
    end else if (drain_act && (row_cnt >= C_IDX_LO) && (row_cnt < C_WIN_END)) begin
      drain.row_idx <= IDX_W'(idx_full);
    end else begin
      drain.row_idx <= '0;
    end
  end

  // sums land in the E stage, E+R+2 .. E+2R
  always_ff @(posedge clk) begin
    if (reset) begin
      drain.sum_receive_en <= 1'b0;
    end else if (drain_act && (row_cnt == C_RX_ON)) begin
      drain.sum_receive_en <= 1'b1;
    end else if (drain_act && (row_cnt == C_WIN_END)) begin
      drain.sum_receive_en <= 1'b0;
    end
  end

  // last row out, pulse at E+2R
  always_ff @(posedge clk) begin
    if (reset) begin
      drain_end <= 1'b0;
    end else begin
      drain_end <= drain_act && (row_cnt == C_END_PRE);
    end
  end

endmodule

//--- design/post_stage_chain.sv
`timescale 1ns/1ps

module post_stage_chain (
  input  logic                             clk,
  input  logic                             reset,
  input  logic                             sum_receive_en,
  input  logic                             drain_end,
  input  logic [conv_ctrl_pkg::MODE_W-1:0] mode,
  output conv_ctrl_pkg::post_ctrl_t        post
);

  // scale, bias, relu, fifo
  localparam int DEPTH = 4;

  logic [DEPTH-1:0] rx_pipe;
  logic [DEPTH-1:0] done_pipe;
  logic             mult_sel;
  logic             mult_q;

  ////////////////////////////////////////////////////////////
  // stage enables
  ////////////////////////////////////////////////////////////

  // bit i is sum_receive_en delayed by i+1
  // end marker rides the same stagger
  always_ff @(posedge clk) begin
    if (reset) begin
      rx_pipe   <= '0;
      done_pipe <= '0;
    end else begin
      rx_pipe   <= {rx_pipe[DEPTH-2:0], sum_receive_en};
      done_pipe <= {done_pipe[DEPTH-2:0], drain_end};
    end
  end

  // mode is stable for the whole tile
  assign mult_sel = (mode == conv_ctrl_pkg::MODE_MULT_ARRAY);

  // same timing as scale_en
  always_ff @(posedge clk) begin
    if (reset) begin
      mult_q <= 1'b0;
    end else begin
      mult_q <= sum_receive_en && mult_sel;
    end
  end

  ////////////////////////////////////////////////////////////
  // bundle out
  ////////////////////////////////////////////////////////////

  assign post.scale_en  = rx_pipe[0];
  assign post.mult_mode = mult_q;
  assign post.bias_en   = rx_pipe[1];
  assign post.relu_en   = rx_pipe[2];
  assign post.fifo_en   = rx_pipe[3];

  // last fifo write of the tile, E+2R+4
  assign post.tile_done = done_pipe[DEPTH-1];

endmodule

//--- design/conv_tile_ctrl.sv
`timescale 1ns/1ps

module conv_tile_ctrl #(
  parameter int sa_rows = 16
) (
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       start,
  input  conv_ctrl_pkg::tile_cfg_t   cfg,
  output conv_ctrl_pkg::array_ctrl_t array,
  output conv_ctrl_pkg::drain_ctrl_t drain,
  output conv_ctrl_pkg::post_ctrl_t  post
);

  // handshakes between the phases
  logic accepted;
  logic pixel_last;
  logic pixel_end;
  logic drain_busy;
  logic drain_end;

  // latched tile mode
  logic [conv_ctrl_pkg::MODE_W-1:0] mode;

  // array control pieces
  logic sa_en;
  logic sa_clear;
  logic cell_en;
  logic cell_clear;
  logic cell_output_en;

  ////////////////////////////////////////////////////////////
  // accumulate phase
  ////////////////////////////////////////////////////////////

  pixel_phase u_pixel (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .cfg        (cfg),
    .drain_busy (drain_busy),
    .accepted   (accepted),
    .mode       (mode),
    .pixel_last (pixel_last),
    .pixel_end  (pixel_end),
    .cell_en    (cell_en),
    .cell_clear (cell_clear)
  );

  ////////////////////////////////////////////////////////////
  // drain phase
  ////////////////////////////////////////////////////////////

  drain_phase #(
    .sa_rows (sa_rows)
  ) u_drain (
    .clk            (clk),
    .reset          (reset),
    .accepted       (accepted),
    .pixel_last     (pixel_last),
    .pixel_end      (pixel_end),
    .sa_en          (sa_en),
    .sa_clear       (sa_clear),
    .cell_output_en (cell_output_en),
    .drain          (drain),
    .drain_busy     (drain_busy),
    .drain_end      (drain_end)
  );

  // post chain hangs off the receive window
  post_stage_chain u_post (
    .clk            (clk),
    .reset          (reset),
    .sum_receive_en (drain.sum_receive_en),
    .drain_end      (drain_end),
    .mode           (mode),
    .post           (post)
  );

  // array bundle, cell side from pixel, sa side from drain
  assign array.sa_en          = sa_en;
  assign array.sa_clear       = sa_clear;
  assign array.cell_en        = cell_en;
  assign array.cell_clear     = cell_clear;
  assign array.cell_output_en = cell_output_en;

endmodule

//--- bench/tile_checker.sv
`timescale 1ns/1ps

module tile_checker #(
  parameter int sa_rows = 16
) (
  input logic                       clk,
  input logic                       reset,
  input logic                       start,
  input conv_ctrl_pkg::tile_cfg_t   cfg,
  input conv_ctrl_pkg::array_ctrl_t array,
  input conv_ctrl_pkg::drain_ctrl_t drain,
  input conv_ctrl_pkg::post_ctrl_t  post
);

  // all three bundles side by side
  typedef struct packed {
    conv_ctrl_pkg::array_ctrl_t a;
    conv_ctrl_pkg::drain_ctrl_t d;
    conv_ctrl_pkg::post_ctrl_t  p;
  } ctrl_t;

  int errors = 0;
  int cyc = 0;

  // reference record, current tile and the one still draining
  int   free_at;
  logic cur_valid;
  logic prev_valid;
  int   cur_s;
  int   cur_n;
  int   prev_s;
  int   prev_n;
  logic [conv_ctrl_pkg::MODE_W-1:0] cur_mode;
  logic [conv_ctrl_pkg::MODE_W-1:0] prev_mode;

  always @(posedge clk) begin
    cyc <= cyc + 1;
  end

  function automatic bit in_window(input int t, input int lo, input int hi);
    return (t >= lo) && (t <= hi);
  endfunction

  ////////////////////////////////////////////////////////////
  // reference cycle model
  ////////////////////////////////////////////////////////////

  // expected bundles of one tile in cycle t, E = S+N+1
  function automatic ctrl_t tile_expect(input int s, input int n,
      input logic [conv_ctrl_pkg::MODE_W-1:0] m, input int t);
    ctrl_t x;
    int    e;
    int    k;
    int    rx_lo;
    int    rx_hi;
    x     = '0;
    e     = s + n + 1;
    k     = t - e - sa_rows;
    rx_lo = e + sa_rows + 2;
    rx_hi = e + 2 * sa_rows;
    // accumulate side
    x.a.cell_en    = in_window(t, s + 2, s + n);
    x.a.cell_clear = (t == e);
    // array enable from S, clear right after it drops
    x.a.sa_en          = in_window(t, s, e + 2 * sa_rows - 2);
    x.a.sa_clear       = (t == e + 2 * sa_rows - 1);
    x.a.cell_output_en = in_window(t, e, e + 2 * sa_rows);
    // row k at E+R+k
    if (k >= 1 && k <= sa_rows) begin
      x.d.row_idx = k[conv_ctrl_pkg::ROW_IDX_W-1:0];
    end
    x.d.sum_receive_en = in_window(t, rx_lo, rx_hi);
    // post stages trail the receive window
    x.p.scale_en  = in_window(t, rx_lo + 1, rx_hi + 1);
    x.p.bias_en   = in_window(t, rx_lo + 2, rx_hi + 2);
    x.p.relu_en   = in_window(t, rx_lo + 3, rx_hi + 3);
    x.p.fifo_en   = in_window(t, rx_lo + 4, rx_hi + 4);
    // multiplier path only for mode 1
    x.p.mult_mode = x.p.scale_en && (m == 4'd1);
    x.p.tile_done = (t == e + 2 * sa_rows + 4);
    return x;
  endfunction

  task automatic compare_bundle(input string name, input logic [7:0] got,
      input logic [7:0] exp);
    assert (got === exp) else begin
      $display("CHECK FAILED %s at cycle %0d: got 0x%0h expected 0x%0h",
               name, cyc, got, exp);
      errors++;
    end
  endtask

  ////////////////////////////////////////////////////////////
  // per-cycle compare, mid-cycle where all is settled
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    ctrl_t exp_now;
    if (reset) begin
      cur_valid  = 1'b0;
      prev_valid = 1'b0;
      free_at    = 0;
    end else begin
      // accepted only once the last drain is over
      if (start && cyc >= free_at) begin
        prev_valid = cur_valid;
        prev_s     = cur_s;
        prev_n     = cur_n;
        prev_mode  = cur_mode;
        cur_valid  = 1'b1;
        cur_s      = cyc;
        cur_n      = int'(cfg.mac_count);
        cur_mode   = cfg.mode;
        free_at    = cyc + cur_n + 1 + 2 * sa_rows + 2;
      end
      exp_now = '0;
      if (cur_valid) begin
        exp_now = exp_now | tile_expect(cur_s, cur_n, cur_mode, cyc);
      end
      if (prev_valid) begin
        exp_now = exp_now | tile_expect(prev_s, prev_n, prev_mode, cyc);
      end
      compare_bundle("array", 8'(array), 8'(exp_now.a));
      compare_bundle("drain", 8'(drain), 8'(exp_now.d));
      compare_bundle("post", 8'(post), 8'(exp_now.p));
    end
  end

endmodule

//--- bench/conv_tile_ctrl_tb.sv
`timescale 1ns/1ps

module conv_tile_ctrl_tb;

  localparam int sa_rows      = 8;
  localparam int tile_count   = 12;
  localparam int done_timeout = 400;

  logic                       clk;
  logic                       reset;
  logic                       start;
  conv_ctrl_pkg::tile_cfg_t   cfg;
  conv_ctrl_pkg::array_ctrl_t array;
  conv_ctrl_pkg::drain_ctrl_t drain;
  conv_ctrl_pkg::post_ctrl_t  post;

  logic [31:0] rng_state;
  int          timeouts;
  int          tiles_done;

  conv_tile_ctrl #(.sa_rows(sa_rows)) dut0 (
    .clk   (clk),
    .reset (reset),
    .start (start),
    .cfg   (cfg),
    .array (array),
    .drain (drain),
    .post  (post)
  );

  tile_checker #(.sa_rows(sa_rows)) chk0 (
    .clk   (clk),
    .reset (reset),
    .start (start),
    .cfg   (cfg),
    .array (array),
    .drain (drain),
    .post  (post)
  );

  // 10 ns period
  initial clk = 1'b0;
  always #5 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // 0 .. bound-1
  function automatic int rand_below(input int bound);
    rng_state = xorshift32(rng_state);
    return int'(rng_state % 32'(bound));
  endfunction

  function automatic conv_ctrl_pkg::tile_cfg_t make_cfg(input int n,
      input logic [conv_ctrl_pkg::MODE_W-1:0] mode);
    conv_ctrl_pkg::tile_cfg_t c;
    c.mode      = mode;
    c.mac_count = n[conv_ctrl_pkg::MAC_COUNT_W-1:0];
    return c;
  endfunction

  // one-cycle start strobe
  task automatic issue_start(input conv_ctrl_pkg::tile_cfg_t c);
    @(posedge clk);
    start <= 1'b1;
    cfg   <= c;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic wait_tile_done(input int tile, output bit ok);
    int waited;
    ok     = 1'b0;
    waited = 0;
    while (!ok && waited < done_timeout) begin
      @(negedge clk);
      waited++;
      if (post.tile_done) begin
        ok = 1'b1;
      end
    end
    if (!ok) begin
      $display("timeout: tile %0d gave no tile_done within %0d cycles", tile, done_timeout);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    int   i;
    int   n;
    int   gap;
    bit   ok;
    logic [conv_ctrl_pkg::MODE_W-1:0] mode;
    reset      = 1'b1;
    start      = 1'b0;
    cfg        = '0;
    rng_state  = 32'he2ac2595;
    timeouts   = 0;
    tiles_done = 0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;
    // quiet stretch before the first tile
    repeat (5) @(posedge clk);
    for (i = 0; i < tile_count && timeouts == 0; i++) begin
      n    = 2 + rand_below(39);
      // every third tile goes through the multiplier array
      mode = (i % 3 == 0) ? 4'd1 : 4'(rand_below(16));
      issue_start(make_cfg(n, mode));
      // odd tiles get a stray start, dropped while a tile is busy
      if (i % 2 == 1) begin
        gap = rand_below(n + 2 * sa_rows);
        repeat (gap) @(posedge clk);
        issue_start(make_cfg(2 + rand_below(39), 4'(rand_below(16))));
      end else if (i % 4 == 2) begin
        // start at E+2R is dropped, the one at E+2R+2 overlaps the post tail
        repeat (n + 2 * sa_rows - 1) @(posedge clk);
        issue_start(make_cfg(2 + rand_below(39), 4'(rand_below(16))));
        issue_start(make_cfg(2 + rand_below(39), 4'd1));
      end
      wait_tile_done(i, ok);
      if (ok) begin
        tiles_done++;
      end else begin
        timeouts++;
      end
    end
    // let trailing outputs settle back to zero
    repeat (6) @(posedge clk);
    $display("errors: %0d check failures, %0d timeouts, %0d of %0d tiles done",
             chk0.errors, timeouts, tiles_done, tile_count);
    if (chk0.errors == 0 && timeouts == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- sim.f
design/conv_ctrl_pkg.sv
design/pixel_phase.sv
design/drain_phase.sv
design/post_stage_chain.sv
design/conv_tile_ctrl.sv
bench/tile_checker.sv
bench/conv_tile_ctrl_tb.sv

//--- Makefile
# Verilator flow for the convolution tile sequencer

VERILATOR  ?= verilator
TOP        ?= conv_tile_ctrl_tb
RTL_TOP    ?= conv_tile_ctrl
FILELIST   ?= sim.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
JOBS       ?= 0
SIM_FLAGS  ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
